// ==== tb.f ====
+incdir+hw
hw/axi_rd_pkg.sv
hw/burst_counter.sv
hw/xfer_request.sv
hw/ar_issuer.sv
hw/r_completion.sv
hw/stream_fifo.sv
hw/axi_read_master.sv
verification/axi_mem_model.sv
verification/tb_axi_read_master.sv

// ==== Makefile ====
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal -f tb.f --top-module tb_axi_read_master -Mdir $(BUILD)
	-./$(BUILD)/Vtb_axi_read_master > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/tb_axi_read_master.sv ====
`default_nettype none

module tb_axi_read_master;

  import axi_rd_pkg::*;

  localparam int num_req     = 12;
  localparam int burst_beats = 256;
  localparam int burst_bytes = 1024;
  localparam int max_pending = 4;

  logic       aclk;
  logic       areset;
  logic       ctrl_start;
  addr_t      ctrl_addr_offset;
  xfer_size_t ctrl_xfer_size_in_bytes;
  logic       ctrl_done;
  logic       m_axi_arvalid;
  logic       m_axi_arready;
  addr_t      m_axi_araddr;
  arlen_t     m_axi_arlen;
  logic       m_axi_rvalid;
  logic       m_axi_rready;
  data_t      m_axi_rdata;
  logic       m_axi_rlast;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  data_t      m_axis_tdata;
  logic       m_axis_tlast;
  logic       ar_stall;
  logic       r_stall;

  logic [31:0] lfsr;
  addr_t       req_offset[num_req];
  xfer_size_t  req_size[num_req];
  int          limit_cycles;
  int          err_count;
  logic        started;
  logic        req_active;
  logic        heavy_backpressure;

  // Expected AR bursts and stream beats in arrival order
  addr_t  exp_ar_addr[$];
  arlen_t exp_ar_len[$];
  data_t  exp_data[$];
  logic   exp_last[$];

  // Running totals from the monitor
  int stream_total;
  int r_total;
  int done_total;
  int pending;
  // Totals as they stood when the current request started
  int stream_base;
  int r_base;
  int done_base;
  int cur_beats;
  addr_t  want_addr;
  arlen_t want_len;

  axi_read_master dut0 (
    .aclk (aclk), .areset (areset),
    .ctrl_start (ctrl_start), .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes), .ctrl_done (ctrl_done),
    .m_axi_arvalid (m_axi_arvalid), .m_axi_arready (m_axi_arready),
    .m_axi_araddr (m_axi_araddr), .m_axi_arlen (m_axi_arlen),
    .m_axi_rvalid (m_axi_rvalid), .m_axi_rready (m_axi_rready),
    .m_axi_rdata (m_axi_rdata), .m_axi_rlast (m_axi_rlast),
    .m_axis_tvalid (m_axis_tvalid), .m_axis_tready (m_axis_tready),
    .m_axis_tdata (m_axis_tdata), .m_axis_tlast (m_axis_tlast)
  );

  // Slave with random arready and rvalid gaps
  axi_mem_model u_mem (
    .aclk (aclk), .areset (areset), .ar_stall (ar_stall), .r_stall (r_stall),
    .arvalid (m_axi_arvalid), .arready (m_axi_arready),
    .araddr (m_axi_araddr), .arlen (m_axi_arlen),
    .rvalid (m_axi_rvalid), .rready (m_axi_rready),
    .rdata (m_axi_rdata), .rlast (m_axi_rlast)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and result checks
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_len(input string name, input arlen_t got, input arlen_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Advance one clock and draw the slave and consumer stalls
  task automatic next_cycle();
    @(posedge aclk);
    #1;
    ar_stall      = (rand_bits(2) == 0);
    r_stall       = (rand_bits(2) == 0);
    // Odd requests keep tready mostly low so the FIFO fills
    m_axis_tready = heavy_backpressure ? (rand_bits(2) == 0) : (rand_bits(2) != 0);
  endtask

  // Reference split of a request into bursts and beats
  task automatic load_expected(input addr_t offset, input xfer_size_t size);
    addr_t base;
    addr_t addr;
    int    bursts;
    base      = (offset / addr_t'(burst_bytes)) * addr_t'(burst_bytes);
    cur_beats = (int'(size) + 3) / 4;
    bursts    = (cur_beats + burst_beats - 1) / burst_beats;
    for (int b = 0; b < bursts; b++) begin
      exp_ar_addr.push_back(base + addr_t'(b * burst_bytes));
      // Only the closing burst is short
      if (b == bursts - 1) begin
        exp_ar_len.push_back(arlen_t'((cur_beats - 1) % burst_beats));
      end else begin
        exp_ar_len.push_back(arlen_t'(burst_beats - 1));
      end
    end
    // Word pattern of the slave, tlast at every burst end
    for (int i = 0; i < cur_beats; i++) begin
      addr = base + addr_t'((i / burst_beats) * burst_bytes + (i % burst_beats) * 4);
      exp_data.push_back(data_t'(addr >> 2) ^ 32'h5a5a0000);
      exp_last.push_back(((i % burst_beats) == burst_beats - 1) || (i == cur_beats - 1));
    end
  endtask

  task automatic run_request(input int idx);
    int errs_before;
    int done_seen;
    int wait_limit;
    int waited;
    errs_before        = err_count;
    heavy_backpressure = (idx % 2) == 1;
    load_expected(req_offset[idx], req_size[idx]);
    wait_limit  = 10 * cur_beats + 100;
    waited      = 0;
    stream_base = stream_total;
    r_base      = r_total;
    done_base   = done_total;
    req_active  = 1'b1;
    started     = 1'b1;
    ctrl_start              = 1'b1;
    ctrl_addr_offset        = req_offset[idx];
    ctrl_xfer_size_in_bytes = req_size[idx];
    next_cycle();
    ctrl_start = 1'b0;
    // Done may come before the FIFO has drained
    while ((stream_total - stream_base < cur_beats || done_total == done_base) &&
           waited < wait_limit) begin
      next_cycle();
      waited++;
    end
    // A few more cycles to catch a stray second done
    repeat (4) next_cycle();
    if (stream_total - stream_base != cur_beats) begin
      report_error($sformatf("stream delivered %0d beats where %0d were expected",
                             stream_total - stream_base, cur_beats));
    end
    done_seen = done_total - done_base;
    if (done_seen != 1) begin
      report_error($sformatf("ctrl_done pulsed %0d times for one request", done_seen));
    end
    if (exp_ar_addr.size() != 0) begin
      report_error("engine issued fewer AR bursts than the request needs");
    end
    // Leftovers of a broken request must not shift the next one
    exp_ar_addr.delete();
    exp_ar_len.delete();
    exp_data.delete();
    exp_last.delete();
    req_active = 1'b0;
    $display("test %0d offset %h size %0d beats %0d: %s", idx, req_offset[idx],
             req_size[idx], cur_beats, (err_count == errs_before) ? "ok" : "errors");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor sampling at the falling edge where all signals are stable
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge aclk) begin
    if (!areset) begin
      // R channel is never throttled
      check_flag("m_axi_rready", m_axi_rready, 1'b1);
      if (!started && (m_axi_arvalid || m_axis_tvalid || ctrl_done)) begin
        report_error("DUT output went active before the first request");
      end
      if (m_axi_arvalid && m_axi_arready) begin
        if (exp_ar_addr.size() == 0) begin
          report_error("AR handshake beyond the expected bursts");
        end else begin
          want_addr = exp_ar_addr.pop_front();
          want_len  = exp_ar_len.pop_front();
          check_addr("m_axi_araddr", m_axi_araddr, want_addr);
          check_len("m_axi_arlen", m_axi_arlen, want_len);
        end
        pending++;
      end
      if (m_axi_rvalid && m_axi_rready) begin
        r_total++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_data.size() == 0) begin
          report_error("stream delivered a beat beyond the request");
        end else begin
          check_data("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
          check_flag("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
        end
        stream_total++;
        if (m_axis_tlast) begin
          pending--;
        end
      end
      // Slots only come back as whole bursts leave the stream
      if (pending > max_pending) begin
        report_error($sformatf("%0d bursts outstanding beyond the stream", pending));
      end
      if (ctrl_done) begin
        if (!req_active) begin
          report_error("ctrl_done pulsed with no request in progress");
        end else if (r_total - r_base != cur_beats) begin
          report_error("ctrl_done pulsed before the last R beat arrived");
        end
        done_total++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    m_axis_tready           = 1'b0;
    ar_stall                = 1'b0;
    r_stall                 = 1'b0;
    lfsr                    = 32'he051;
    err_count               = 0;
    started                 = 1'b0;
    req_active              = 1'b0;
    heavy_backpressure      = 1'b0;
    stream_total            = 0;
    r_total                 = 0;
    done_total              = 0;
    pending                 = 0;
    cur_beats               = 0;
    limit_cycles            = 0;

    // Fixed single beat and four full bursts lead the random requests
    for (int i = 0; i < num_req; i++) begin
      req_offset[i] = rand_bits(32);
      req_size[i]   = xfer_size_t'(1 + rand_bits(13) % 6000);
    end
    req_size[0] = xfer_size_t'(1);
    req_size[1] = xfer_size_t'(4096);
    // Run budget from the total beat count
    for (int i = 0; i < num_req; i++) begin
      limit_cycles += 20 * ((int'(req_size[i]) + 3) / 4) + 200;
    end

    repeat (2) next_cycle();
    areset = 1'b0;
    repeat (5) next_cycle();
    for (int i = 0; i < num_req; i++) begin
      run_request(i);
      repeat (3) next_cycle();
    end

    $display("tests %0d errors %0d", num_req, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge aclk);
    $display("TIMEOUT: run did not finish within %0d cycles", limit_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/axi_mem_model.sv ====
`default_nettype none

// AXI4 read slave for the testbench
// Bursts are served in order, each word is its word address xor a fixed pattern
module axi_mem_model (
  input  logic               aclk,
  input  logic               areset,
  input  logic               ar_stall,
  input  logic               r_stall,
  input  logic               arvalid,
  output logic               arready,
  input  axi_rd_pkg::addr_t  araddr,
  input  axi_rd_pkg::arlen_t arlen,
  output logic               rvalid,
  input  logic               rready,
  output axi_rd_pkg::data_t  rdata,
  output logic               rlast
);

  import axi_rd_pkg::*;

  // Accepted bursts waiting for their data
  addr_t  burst_addr[$];
  arlen_t burst_len[$];
  int     beat;
  logic   rst_s;
  logic   ar_stall_s;
  logic   r_stall_s;

  // Data pattern on top of the word address
  function automatic data_t word_at(input addr_t addr);
    return data_t'(addr >> 2) ^ 32'h5a5a0000;
  endfunction

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rlast   = 1'b0;
    beat    = 0;
    forever begin
      // Handshakes settle well before the falling edge
      @(negedge aclk);
      if (areset) begin
        burst_addr.delete();
        burst_len.delete();
        beat = 0;
      end else begin
        if (arvalid && arready) begin
          burst_addr.push_back(araddr);
          burst_len.push_back(arlen);
        end
        if (rvalid && rready) begin
          // Retire the burst on its final beat
          if (beat == int'(burst_len[0])) begin
            void'(burst_addr.pop_front());
            void'(burst_len.pop_front());
            beat = 0;
          end else begin
            beat++;
          end
        end
      end
      rst_s      = areset;
      ar_stall_s = ar_stall;
      r_stall_s  = r_stall;

      // New outputs a little after the rising edge
      @(posedge aclk);
      #1;
      arready = !rst_s && !ar_stall_s;
      if (!rst_s && !r_stall_s && burst_len.size() != 0) begin
        rvalid = 1'b1;
        rdata  = word_at(burst_addr[0] + addr_t'(beat * 4));
        rlast  = (beat == int'(burst_len[0]));
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_read_master.sv ====
`default_nettype none

// Burst read engine, AXI4 read port in and AXI4-Stream out
module axi_read_master (
  input  logic                   aclk,
  input  logic                   areset,

  // Control
  input  logic                   ctrl_start,
  input  axi_rd_pkg::addr_t      ctrl_addr_offset,
  input  axi_rd_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  output logic                   ctrl_done,

  // AXI4 read address channel
  output logic                   m_axi_arvalid,
  input  logic                   m_axi_arready,
  output axi_rd_pkg::addr_t      m_axi_araddr,
  output axi_rd_pkg::arlen_t     m_axi_arlen,

  // AXI4 read data channel
  input  logic                   m_axi_rvalid,
  output logic                   m_axi_rready,
  input  axi_rd_pkg::data_t      m_axi_rdata,
  input  logic                   m_axi_rlast,

  // AXI4-Stream output
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output axi_rd_pkg::data_t      m_axis_tdata,
  output logic                   m_axis_tlast
);

  import axi_rd_pkg::*;

  logic       launch;
  addr_t      base_addr;
  burst_cnt_t num_bursts;
  arlen_t     final_len;

  // FIFO always has room for every issued burst
  assign m_axi_rready = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Request and address path
  ////////////////////////////////////////////////////////////////////////////

  xfer_request u_xfer_request (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .launch                  (launch),
    .base_addr               (base_addr),
    .num_bursts              (num_bursts),
    .final_len               (final_len)
  );

  // Watches the stream side to return burst slots
  ar_issuer u_ar_issuer (
    .aclk          (aclk),
    .areset        (areset),
    .launch        (launch),
    .base_addr     (base_addr),
    .num_bursts    (num_bursts),
    .final_len     (final_len),
    .m_axi_arready (m_axi_arready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  r_completion u_r_completion (
    .aclk         (aclk),
    .areset       (areset),
    .launch       (launch),
    .m_axi_rvalid (m_axi_rvalid),
    .m_axi_rlast  (m_axi_rlast),
    .num_bursts   (num_bursts),
    .ctrl_done    (ctrl_done)
  );

  stream_fifo u_stream_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_en    (m_axi_rvalid),
    .wr_last  (m_axi_rlast),
    .wr_data  (m_axi_rdata),
    .rd_ready (m_axis_tready),
    .rd_valid (m_axis_tvalid),
    .rd_last  (m_axis_tlast),
    .rd_data  (m_axis_tdata)
  );

endmodule

`default_nettype wire

// ==== hw/stream_fifo.sv ====
`default_nettype none

`include "axi_rd_macros.svh"

// First-word-fall-through FIFO between R and the stream
module stream_fifo (
  input  logic              aclk,
  input  logic              areset,
  input  logic              wr_en,
  input  logic              wr_last,
  input  axi_rd_pkg::data_t wr_data,
  input  logic              rd_ready,
  output logic              rd_valid,
  output logic              rd_last,
  output axi_rd_pkg::data_t rd_data
);

  import axi_rd_pkg::*;

  localparam int depth  = `AXI_RD_FIFO_DEPTH;
  localparam int addr_w = $clog2(depth);

  // Each entry is last flag above the data word
  logic [$bits(data_t):0] mem [depth];
  logic [addr_w:0]        wr_ptr;
  logic [addr_w:0]        rd_ptr;
  logic                   mem_empty;
  logic                   out_free;
  logic                   bypass;

  // Extra pointer bit keeps a full array apart from an empty one
  assign mem_empty = (wr_ptr == rd_ptr);

  // Output register empty or emptied this cycle
  assign out_free  = !rd_valid || rd_ready;

  // Write goes straight to the output when nothing is queued ahead
  assign bypass    = wr_en && out_free && mem_empty;

  ////////////////////////////////////////////////////////////////////////////
  // Storage array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en && !bypass) begin
      mem[wr_ptr[addr_w-1:0]] <= {wr_last, wr_data};
    end
  end

  // No full check, outstanding limit keeps room
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en && !bypass) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_free && !mem_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_valid <= 1'b0;
    end else if (out_free) begin
      rd_valid <= !mem_empty || wr_en;
    end
  end

  // Oldest queued word first, else the incoming one
  always_ff @(posedge aclk) begin
    if (out_free) begin
      if (!mem_empty) begin
        {rd_last, rd_data} <= mem[rd_ptr[addr_w-1:0]];
      end else if (wr_en) begin
        {rd_last, rd_data} <= {wr_last, wr_data};
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/r_completion.sv ====
`default_nettype none

`include "axi_rd_macros.svh"

// R burst tracking and done pulse
module r_completion (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   launch,
  input  logic                   m_axi_rvalid,
  input  logic                   m_axi_rlast,
  input  axi_rd_pkg::burst_cnt_t num_bursts,
  output logic                   ctrl_done
);

  logic rlast_beat;
  logic final_burst;

  // rready is tied high, so every rvalid cycle is a beat
  assign rlast_beat = m_axi_rvalid && m_axi_rlast;

  ////////////////////////////////////////////////////////////////////////////
  // Bursts still to complete
  ////////////////////////////////////////////////////////////////////////////

  // Same count as the issuer, walked down by rlast
  burst_counter #(
    .width      (`AXI_RD_BURST_CNT_W),
    .init_value ('0)
  ) u_r_bursts (
    .aclk       (aclk),
    .areset     (areset),
    .load       (launch),
    .load_value (num_bursts),
    .incr       (1'b0),
    .decr       (rlast_beat),
    .count      (),
    .is_zero    (final_burst)
  );

  // One cycle pulse after the last beat of the last burst
  // FIFO may still hold data at this point
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= rlast_beat && final_burst;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ar_issuer.sv ====
`default_nettype none

`include "axi_rd_macros.svh"

// Read address channel driver with outstanding burst limit
module ar_issuer (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   launch,
  input  axi_rd_pkg::addr_t      base_addr,
  input  axi_rd_pkg::burst_cnt_t num_bursts,
  input  axi_rd_pkg::arlen_t     final_len,
  input  logic                   m_axi_arready,
  input  logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  input  logic                   m_axis_tlast,
  output logic                   m_axi_arvalid,
  output axi_rd_pkg::addr_t      m_axi_araddr,
  output axi_rd_pkg::arlen_t     m_axi_arlen
);

  import axi_rd_pkg::*;

  localparam arlen_t   full_len     = arlen_t'(`AXI_RD_BURST_LEN - 1);
  localparam vacancy_t vacancy_init = vacancy_t'(`AXI_RD_MAX_OUTSTANDING);

  ar_state_e state;
  ar_state_e state_next;
  logic      arxfer;
  logic      slot_freed;
  logic      last_burst;
  vacancy_t  vacancy;
  addr_t     addr_r;

  // AR handshake and a burst fully drained from the stream
  assign arxfer     = m_axi_arvalid && m_axi_arready;
  assign slot_freed = m_axis_tvalid && m_axis_tready && m_axis_tlast;

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  // Bursts to go, zero marks the last one
  burst_counter #(
    .width      (`AXI_RD_BURST_CNT_W),
    .init_value ('0)
  ) u_bursts_to_go (
    .aclk       (aclk),
    .areset     (areset),
    .load       (launch),
    .load_value (num_bursts),
    .incr       (1'b0),
    .decr       (arxfer),
    .count      (),
    .is_zero    (last_burst)
  );

  // Free slots, taken per AR transfer and returned per tlast beat
  burst_counter #(
    .width      (`AXI_RD_VACANCY_W),
    .init_value (vacancy_init)
  ) u_vacancy (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .load_value ('0),
    .incr       (slot_freed),
    .decr       (arxfer),
    .count      (vacancy),
    .is_zero    ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      AR_IDLE: begin
        // A request always has at least one burst
        if (launch) begin
          state_next = (vacancy != '0) ? AR_ISSUE : AR_GAP;
        end
      end
      AR_ISSUE: begin
        if (arxfer) begin
          state_next = last_burst ? AR_IDLE : AR_GAP;
        end
      end
      AR_GAP: begin
        // Wait here for a free slot
        if (vacancy != '0) begin
          state_next = AR_ISSUE;
        end
      end
      default: state_next = AR_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= AR_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign m_axi_arvalid = (state == AR_ISSUE);

  // Address steps one full burst per transfer
  always_ff @(posedge aclk) begin
    if (launch) begin
      addr_r <= base_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + addr_t'(`AXI_RD_BURST_BYTES);
    end
  end

  assign m_axi_araddr = addr_r;

  // Only the last burst is short
  assign m_axi_arlen  = last_burst ? final_len : full_len;

endmodule

`default_nettype wire

// ==== hw/xfer_request.sv ====
`default_nettype none

`include "axi_rd_macros.svh"

// Request capture and split into bursts
module xfer_request (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  axi_rd_pkg::addr_t      ctrl_addr_offset,
  input  axi_rd_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  output logic                   launch,
  output axi_rd_pkg::addr_t      base_addr,
  output axi_rd_pkg::burst_cnt_t num_bursts,
  output axi_rd_pkg::arlen_t     final_len
);

  import axi_rd_pkg::*;

  // Low address bits inside one full burst
  localparam addr_t burst_mask = addr_t'(`AXI_RD_BURST_BYTES - 1);

  logic                                start_d1;
  logic [`AXI_RD_TOTAL_LEN_W-1:0]      size_words;
  logic [`AXI_RD_LOG_DW_BYTES-1:0]     size_rem;
  logic [`AXI_RD_TOTAL_LEN_W-1:0]      total_len_r;

  ////////////////////////////////////////////////////////////////////////////
  // Size rounding and address alignment
  ////////////////////////////////////////////////////////////////////////////

  // Whole words and leftover bytes of the request
  assign size_words = ctrl_xfer_size_in_bytes[`AXI_RD_XFER_W-1:`AXI_RD_LOG_DW_BYTES];
  assign size_rem   = ctrl_xfer_size_in_bytes[`AXI_RD_LOG_DW_BYTES-1:0];

  // Beats minus one, a partial word counts as a full beat
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      total_len_r <= (size_rem != '0) ? size_words : size_words - 1'b1;
      // Start on a burst boundary so no burst crosses 4 KB
      base_addr   <= ctrl_addr_offset & ~burst_mask;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Launch timing
  ////////////////////////////////////////////////////////////////////////////

  // Two stages give the size registers time to settle
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      launch   <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      launch   <= start_d1;
    end
  end

  // Upper beat bits count the extra bursts beyond the first
  assign num_bursts = total_len_r[`AXI_RD_TOTAL_LEN_W-1:`AXI_RD_LOG_BURST_LEN];

  // Lower beat bits give the length of the final burst
  assign final_len  = total_len_r[`AXI_RD_LOG_BURST_LEN-1:0];

endmodule

`default_nettype wire

// ==== hw/burst_counter.sv ====
`default_nettype none

// Loadable up/down counter with a zero flag
module burst_counter #(
  parameter int width = 8,
  parameter logic [width-1:0] init_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic [width-1:0] load_value,
  input  logic             incr,
  input  logic             decr,
  output logic [width-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Incr and decr together cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init_value;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  // Zero flag straight from the count
  assign is_zero = (count == '0);

endmodule

`default_nettype wire

// ==== hw/axi_rd_pkg.sv ====
`default_nettype none

`include "axi_rd_macros.svh"

package axi_rd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and request types
  ////////////////////////////////////////////////////////////////////////////

  // Byte address on the AR channel
  typedef logic [`AXI_RD_ADDR_W-1:0] addr_t;

  // One data word on R and on the stream
  typedef logic [`AXI_RD_DATA_W-1:0] data_t;

  // Request size in bytes
  typedef logic [`AXI_RD_XFER_W-1:0] xfer_size_t;

  // AXI burst length, beats minus one
  typedef logic [7:0] arlen_t;

  // Bursts still to go, also minus one
  typedef logic [`AXI_RD_BURST_CNT_W-1:0] burst_cnt_t;

  // Free outstanding burst slots
  typedef logic [`AXI_RD_VACANCY_W-1:0] vacancy_t;

  ////////////////////////////////////////////////////////////////////////////
  // Address issuer FSM
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    AR_IDLE  = 2'd0,  // Nothing to issue
    AR_ISSUE = 2'd1,  // arvalid high, waiting on arready
    AR_GAP   = 2'd2   // Between bursts or stalled on the slot limit
  } ar_state_e;

endpackage

`default_nettype wire

// ==== hw/axi_rd_macros.svh ====
`ifndef AXI_RD_MACROS_SVH
`define AXI_RD_MACROS_SVH

// Bus widths
`define AXI_RD_ADDR_W 32
`define AXI_RD_DATA_W 32
`define AXI_RD_XFER_W 20

// Bytes carried by one data beat
`define AXI_RD_DW_BYTES 4
`define AXI_RD_LOG_DW_BYTES 2

// A burst may not cross 4 KB and may not exceed 256 beats
`define AXI_RD_BURST_LEN \
  (((4096 / `AXI_RD_DW_BYTES) < 256) ? (4096 / `AXI_RD_DW_BYTES) : 256)
`define AXI_RD_LOG_BURST_LEN 8
`define AXI_RD_BURST_BYTES (`AXI_RD_BURST_LEN * `AXI_RD_DW_BYTES)

// Beat count and burst count widths derived from the byte count width
`define AXI_RD_TOTAL_LEN_W (`AXI_RD_XFER_W - `AXI_RD_LOG_DW_BYTES)
`define AXI_RD_BURST_CNT_W (`AXI_RD_TOTAL_LEN_W - `AXI_RD_LOG_BURST_LEN)

// Outstanding burst limit and its counter width
`define AXI_RD_MAX_OUTSTANDING 4
`define AXI_RD_VACANCY_W ($clog2(`AXI_RD_MAX_OUTSTANDING + 1))

// Data FIFO holds every outstanding burst, power of two
`define AXI_RD_FIFO_DEPTH \
  (2 ** ($clog2(`AXI_RD_BURST_LEN * `AXI_RD_MAX_OUTSTANDING)))

`endif
